// ==== common/mmu_settings.svh ====
/*
 * Sv39 walker settings
 * widths shared by the package and the walker RTL
 */

`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// virtual address, Sv39
`define MMU_VA_WIDTH 39
// physical page number
`define MMU_PPN_WIDTH 22
// physical address, ppn plus page offset
`define MMU_PA_WIDTH 34
// address space id
`define MMU_ASID_WIDTH 8
// top-of-range pmp entries
`define MMU_PMP_ENTRIES 4
// saturating miss counters
`define MMU_CNT_WIDTH 16

`endif

// ==== common/mmu_pkg.sv ====
/*
 * MMU page walk types
 * pte layout, walk request, memory port, walk outcome,
 * tlb fill, fault report and pmp configuration
 */

`default_nettype none

`include "mmu_settings.svh"

package mmu_pkg;

  typedef enum logic [1:0] {FAULT_NONE, FAULT_PAGE, FAULT_ACCESS} fault_kind_e;
  typedef enum logic [1:0] {SIZE_4K, SIZE_2M, SIZE_1G} page_size_e;

  // Sv39 page table entry, msb first
  typedef struct packed {
    logic [9:0]  reserved;
    logic [43:0] ppn;
    logic [1:0]  rsw;
    logic        d;
    logic        a;
    logic        g;
    logic        u;
    logic        x;
    logic        w;
    logic        r;
    logic        v;
  } pte_t;

  typedef struct packed {
    logic                       valid;
    logic [`MMU_VA_WIDTH-1:0]   vaddr;
    logic [`MMU_ASID_WIDTH-1:0] asid;
    logic                       is_instr;
    logic                       is_store;
  } walk_req_t;

  typedef struct packed {
    logic                     valid;
    logic [`MMU_PA_WIDTH-1:0] paddr;
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] data;
  } mem_rsp_t;

  typedef struct packed {
    logic                       valid;
    logic                       is_instr;
    fault_kind_e                fault_kind;
    logic [`MMU_VA_WIDTH-1:0]   vaddr;
    logic [`MMU_ASID_WIDTH-1:0] asid;
    logic [`MMU_PA_WIDTH-1:0]   bad_paddr;
    pte_t                       pte;
    page_size_e                 size;
  } walk_result_t;

  typedef struct packed {
    logic                       valid;
    logic [26:0]                vpn;
    logic [`MMU_ASID_WIDTH-1:0] asid;
    page_size_e                 size;
    pte_t                       content;
  } tlb_update_t;

  typedef struct packed {
    logic                     valid;
    fault_kind_e              kind;
    logic                     is_instr;
    logic [`MMU_VA_WIDTH-1:0] vaddr;
    logic [`MMU_PA_WIDTH-1:0] bad_paddr;
  } walk_fault_t;

  // pmpcfg byte, only tor addressing here
  typedef struct packed {
    logic       lock;
    logic [2:0] rsvd;
    logic       a_tor;
    logic       x;
    logic       w;
    logic       r;
  } pmp_cfg_t;

endpackage

`default_nettype wire

// ==== ptw/pmp_check.sv ====
/*
 * PMP read check for walker accesses
 * top-of-range entries only, lowest matching entry decides,
 * an address outside all regions is allowed
 */

`timescale 1ns/1ns
`default_nettype none

`include "mmu_settings.svh"

module pmp_check import mmu_pkg::*; (
  input  wire logic [`MMU_PA_WIDTH-1:0]                         paddr_i,
  input  pmp_cfg_t [`MMU_PMP_ENTRIES-1:0]                       pmp_cfg_i,
  input  wire logic [`MMU_PMP_ENTRIES-1:0][`MMU_PA_WIDTH-3:0]   pmp_addr_i,
  output logic                                                  allow_o
);

  // pmp address registers hold the physical address shifted by 2
  logic [`MMU_PA_WIDTH-3:0] addr_word;

  assign addr_word = paddr_i[`MMU_PA_WIDTH-1:2];

  always_comb begin : tor_match
    logic                     matched;
    logic [`MMU_PA_WIDTH-3:0] lower;
    matched = 1'b0;
    allow_o = 1'b1;
    for (int i = 0; i < `MMU_PMP_ENTRIES; i++) begin
      // entry 0 starts at address zero
      lower = (i == 0) ? '0 : pmp_addr_i[i-1];
      if (!matched && pmp_cfg_i[i].a_tor &&
          (addr_word >= lower) && (addr_word < pmp_addr_i[i])) begin
        matched = 1'b1;
        allow_o = pmp_cfg_i[i].r;
      end
    end
  end

endmodule

`default_nettype wire

// ==== ptw/ptw.sv ====
/*
 * Sv39 page table walker
 * up to three levels of pte reads, one read outstanding,
 * leaf permission and superpage alignment checks, pmp check of
 * every pte address, flush with drain of a pending response
 */

`timescale 1ns/1ns
`default_nettype none

`include "mmu_settings.svh"

module ptw import mmu_pkg::*; (
  input  wire logic                                             clk_i,
  input  wire logic                                             rst_i,
  input  wire logic                                             flush_i,
  input  walk_req_t                                             walk_req_i,
  input  wire logic [`MMU_PPN_WIDTH-1:0]                        satp_ppn_i,
  input  wire logic                                             mxr_i,
  input  pmp_cfg_t [`MMU_PMP_ENTRIES-1:0]                       pmp_cfg_i,
  input  wire logic [`MMU_PMP_ENTRIES-1:0][`MMU_PA_WIDTH-3:0]   pmp_addr_i,
  input  mem_rsp_t                                              mem_rsp_i,
  output logic                                                  walker_busy_o,
  output mem_req_t                                              mem_req_o,
  output walk_result_t                                          walk_result_o
);

  typedef enum logic [2:0] {ST_IDLE, ST_REQUEST, ST_LOOKUP, ST_PROPAGATE, ST_DRAIN} state_e;

  state_e                    state_q, state_d;
  // 0 is the 1G level, 2 the 4K level
  logic [1:0]                lvl_q, lvl_d;
  logic [`MMU_PA_WIDTH-1:0]  pptr_q, pptr_d;
  logic                      global_q, global_d;
  walk_req_t                 req_q;
  logic                      rsp_valid_q;
  pte_t                      pte_q;
  mem_req_t                  mem_req_q, mem_req_d;
  logic                      pmp_allow;
  logic                      is_leaf;
  logic                      perm_fault;
  logic                      misaligned;
  logic                      page_fault;
  logic [8:0]                next_idx;

  pmp_check u_pmp_check (
    .paddr_i   (pptr_q),
    .pmp_cfg_i (pmp_cfg_i),
    .pmp_addr_i(pmp_addr_i),
    .allow_o   (pmp_allow)
  );

  assign walker_busy_o = (state_q != ST_IDLE);
  assign mem_req_o     = mem_req_q;

  // ----------------------------------------
  // pte checks on the registered response
  // ----------------------------------------
  assign is_leaf  = pte_q.r || pte_q.x;
  // index for the level below the current one
  assign next_idx = (lvl_q == 2'd0) ? req_q.vaddr[29:21] : req_q.vaddr[20:12];

  always_comb begin
    if (req_q.is_instr) begin
      perm_fault = !(pte_q.x && pte_q.a);
    end else begin
      // loads may read x-only pages when mxr is set
      perm_fault = !(pte_q.a && (pte_q.r || (pte_q.x && mxr_i)));
      if (req_q.is_store && !(pte_q.w && pte_q.d)) begin
        perm_fault = 1'b1;
      end
    end
  end

  // superpage ppn must be aligned to its size
  assign misaligned = ((lvl_q == 2'd0) && (pte_q.ppn[17:0] != '0)) ||
                      ((lvl_q == 2'd1) && (pte_q.ppn[8:0] != '0));

  assign page_fault = !pte_q.v || (pte_q.w && !pte_q.r) ||
                      (!is_leaf && (lvl_q == 2'd2)) ||
                      (is_leaf && (perm_fault || misaligned));

  // ----------------------------------------
  // walk fsm
  // ----------------------------------------
  always_comb begin
    state_d   = state_q;
    lvl_d     = lvl_q;
    pptr_d    = pptr_q;
    global_d  = global_q;
    mem_req_d = '0;

    // result payload follows the walk state, valid only on a decision
    walk_result_o            = '0;
    walk_result_o.is_instr   = req_q.is_instr;
    walk_result_o.vaddr      = req_q.vaddr;
    walk_result_o.asid       = req_q.asid;
    walk_result_o.pte        = pte_q;
    walk_result_o.pte.g      = pte_q.g || global_q;
    walk_result_o.size       = (lvl_q == 2'd0) ? SIZE_1G :
                               (lvl_q == 2'd1) ? SIZE_2M : SIZE_4K;

    case (state_q)
      ST_IDLE: begin
        lvl_d    = 2'd0;
        global_d = 1'b0;
        if (walk_req_i.valid) begin
          // root table from satp, read goes out next cycle
          pptr_d          = {satp_ppn_i, walk_req_i.vaddr[38:30], 3'b000};
          mem_req_d.valid = 1'b1;
          mem_req_d.paddr = pptr_d;
          state_d         = ST_LOOKUP;
        end
      end
      ST_REQUEST: begin
        mem_req_d.valid = 1'b1;
        mem_req_d.paddr = pptr_q;
        state_d         = ST_LOOKUP;
      end
      ST_LOOKUP: begin
        if (rsp_valid_q) begin
          global_d = global_q || pte_q.g;
          if (!pmp_allow) begin
            // pte address itself not readable
            walk_result_o.valid      = 1'b1;
            walk_result_o.fault_kind = FAULT_ACCESS;
            walk_result_o.bad_paddr  = pptr_q;
            state_d                  = ST_PROPAGATE;
          end else if (page_fault) begin
            walk_result_o.valid      = 1'b1;
            walk_result_o.fault_kind = FAULT_PAGE;
            state_d                  = ST_PROPAGATE;
          end else if (is_leaf) begin
            walk_result_o.valid = 1'b1;
            state_d             = ST_PROPAGATE;
          end else begin
            // pointer, descend one level
            lvl_d   = lvl_q + 2'd1;
            pptr_d  = {pte_q.ppn[`MMU_PPN_WIDTH-1:0], next_idx, 3'b000};
            state_d = ST_REQUEST;
          end
        end
      end
      // holds busy over the result stage strobe
      ST_PROPAGATE: begin
        state_d = ST_IDLE;
      end
      ST_DRAIN: begin
        if (rsp_valid_q) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase

    // flush drops the walk, a read already issued must still come back
    if (flush_i) begin
      mem_req_d           = '0;
      walk_result_o.valid = 1'b0;
      if ((state_q inside {ST_LOOKUP, ST_DRAIN}) && !rsp_valid_q) begin
        state_d = ST_DRAIN;
      end else begin
        state_d = ST_IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= ST_IDLE;
      lvl_q       <= 2'd0;
      global_q    <= 1'b0;
      rsp_valid_q <= 1'b0;
      mem_req_q   <= '0;
    end else begin
      state_q     <= state_d;
      lvl_q       <= lvl_d;
      global_q    <= global_d;
      rsp_valid_q <= mem_rsp_i.valid;
      mem_req_q   <= mem_req_d;
    end
    pptr_q <= pptr_d;
    if (mem_rsp_i.valid) begin
      pte_q <= pte_t'(mem_rsp_i.data);
    end
    if ((state_q == ST_IDLE) && walk_req_i.valid) begin
      req_q <= walk_req_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/miss_arbiter.sv ====
/*
 * TLB miss arbiter
 * picks one of the held itlb/dtlb misses while the walker is idle,
 * dtlb first, and registers it as a one-cycle walk request
 */

`timescale 1ns/1ns
`default_nettype none

`include "mmu_settings.svh"

module miss_arbiter import mmu_pkg::*; (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire logic                       flush_i,
  input  wire logic                       itlb_miss_i,
  input  wire logic [`MMU_VA_WIDTH-1:0]   itlb_vaddr_i,
  input  wire logic                       dtlb_miss_i,
  input  wire logic [`MMU_VA_WIDTH-1:0]   dtlb_vaddr_i,
  input  wire logic                       dtlb_is_store_i,
  input  wire logic [`MMU_ASID_WIDTH-1:0] asid_i,
  input  wire logic                       walker_busy_i,
  output walk_req_t                       walk_req_o
);

  walk_req_t req_q;
  logic      pick_ok;

  // busy only rises the cycle after our strobe, so mask that cycle too
  assign pick_ok = !walker_busy_i && !req_q.valid && !flush_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q.valid <= 1'b0;
    end else begin
      req_q.valid <= pick_ok && (dtlb_miss_i || itlb_miss_i);
    end
    // payload, latched on a pick
    if (pick_ok) begin
      req_q.asid <= asid_i;
      if (dtlb_miss_i) begin
        // data side wins a tie
        req_q.vaddr    <= dtlb_vaddr_i;
        req_q.is_instr <= 1'b0;
        req_q.is_store <= dtlb_is_store_i;
      end else begin
        req_q.vaddr    <= itlb_vaddr_i;
        req_q.is_instr <= 1'b1;
        req_q.is_store <= 1'b0;
      end
    end
  end

  assign walk_req_o = req_q;

endmodule

`default_nettype wire

// ==== logic/walk_result_stage.sv ====
/*
 * Walk result stage
 * registers a walker outcome into one itlb update, dtlb update
 * or fault strobe and counts misses per tlb
 */

`timescale 1ns/1ns
`default_nettype none

`include "mmu_settings.svh"

module walk_result_stage import mmu_pkg::*; (
  input  wire logic                      clk_i,
  input  wire logic                      rst_i,
  input  walk_result_t                   walk_result_i,
  output tlb_update_t                    itlb_update_o,
  output tlb_update_t                    dtlb_update_o,
  output walk_fault_t                    walk_fault_o,
  output logic [`MMU_CNT_WIDTH-1:0]      itlb_miss_count_o,
  output logic [`MMU_CNT_WIDTH-1:0]      dtlb_miss_count_o
);

  tlb_update_t upd_q;
  walk_fault_t fault_q;
  logic        itlb_valid_q;
  logic        dtlb_valid_q;
  logic        fault_valid_q;
  logic        success;
  logic        itlb_done;
  logic        dtlb_done;

  assign success   = (walk_result_i.fault_kind == FAULT_NONE);
  assign itlb_done = walk_result_i.valid && walk_result_i.is_instr;
  assign dtlb_done = walk_result_i.valid && !walk_result_i.is_instr;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      itlb_valid_q      <= 1'b0;
      dtlb_valid_q      <= 1'b0;
      fault_valid_q     <= 1'b0;
      itlb_miss_count_o <= '0;
      dtlb_miss_count_o <= '0;
    end else begin
      itlb_valid_q  <= itlb_done && success;
      dtlb_valid_q  <= dtlb_done && success;
      fault_valid_q <= walk_result_i.valid && !success;
      // one count per walk, faulted or not, saturating
      if (itlb_done && (itlb_miss_count_o != '1)) begin
        itlb_miss_count_o <= itlb_miss_count_o + 1'b1;
      end
      if (dtlb_done && (dtlb_miss_count_o != '1)) begin
        dtlb_miss_count_o <= dtlb_miss_count_o + 1'b1;
      end
    end
    // payload shared by both tlb ports
    if (walk_result_i.valid) begin
      upd_q <= '{valid: 1'b0, vpn: walk_result_i.vaddr[38:12], asid: walk_result_i.asid,
                 size: walk_result_i.size, content: walk_result_i.pte};
      fault_q <= '{valid: 1'b0, kind: walk_result_i.fault_kind,
                   is_instr: walk_result_i.is_instr, vaddr: walk_result_i.vaddr,
                   bad_paddr: walk_result_i.bad_paddr};
    end
  end

  always_comb begin
    itlb_update_o       = upd_q;
    itlb_update_o.valid = itlb_valid_q;
    dtlb_update_o       = upd_q;
    dtlb_update_o.valid = dtlb_valid_q;
    walk_fault_o        = fault_q;
    walk_fault_o.valid  = fault_valid_q;
  end

endmodule

`default_nettype wire

// ==== logic/mmu_walk_top.sv ====
/*
 * MMU page walk subsystem top
 * miss arbiter, Sv39 walker and result stage
 */

`timescale 1ns/1ns
`default_nettype none

`include "mmu_settings.svh"

module mmu_walk_top import mmu_pkg::*; (
  input  wire logic                                             clk_i,
  input  wire logic                                             rst_i,
  input  wire logic                                             flush_i,
  input  wire logic                                             itlb_miss_i,
  input  wire logic [`MMU_VA_WIDTH-1:0]                         itlb_vaddr_i,
  input  wire logic                                             dtlb_miss_i,
  input  wire logic [`MMU_VA_WIDTH-1:0]                         dtlb_vaddr_i,
  input  wire logic                                             dtlb_is_store_i,
  input  wire logic [`MMU_ASID_WIDTH-1:0]                       asid_i,
  input  wire logic [`MMU_PPN_WIDTH-1:0]                        satp_ppn_i,
  input  wire logic                                             mxr_i,
  input  pmp_cfg_t [`MMU_PMP_ENTRIES-1:0]                       pmp_cfg_i,
  input  wire logic [`MMU_PMP_ENTRIES-1:0][`MMU_PA_WIDTH-3:0]   pmp_addr_i,
  input  mem_rsp_t                                              mem_rsp_i,
  output mem_req_t                                              mem_req_o,
  output tlb_update_t                                           itlb_update_o,
  output tlb_update_t                                           dtlb_update_o,
  output walk_fault_t                                           walk_fault_o,
  output logic [`MMU_CNT_WIDTH-1:0]                             itlb_miss_count_o,
  output logic [`MMU_CNT_WIDTH-1:0]                             dtlb_miss_count_o
);

  walk_req_t    walk_req;
  walk_result_t walk_result;
  logic         walker_busy;

  miss_arbiter u_miss_arbiter (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .itlb_miss_i    (itlb_miss_i),
    .itlb_vaddr_i   (itlb_vaddr_i),
    .dtlb_miss_i    (dtlb_miss_i),
    .dtlb_vaddr_i   (dtlb_vaddr_i),
    .dtlb_is_store_i(dtlb_is_store_i),
    .asid_i         (asid_i),
    .walker_busy_i  (walker_busy),
    .walk_req_o     (walk_req)
  );

  ptw u_ptw (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .walk_req_i   (walk_req),
    .satp_ppn_i   (satp_ppn_i),
    .mxr_i        (mxr_i),
    .pmp_cfg_i    (pmp_cfg_i),
    .pmp_addr_i   (pmp_addr_i),
    .mem_rsp_i    (mem_rsp_i),
    .walker_busy_o(walker_busy),
    .mem_req_o    (mem_req_o),
    .walk_result_o(walk_result)
  );

  walk_result_stage u_walk_result_stage (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .walk_result_i    (walk_result),
    .itlb_update_o    (itlb_update_o),
    .dtlb_update_o    (dtlb_update_o),
    .walk_fault_o     (walk_fault_o),
    .itlb_miss_count_o(itlb_miss_count_o),
    .dtlb_miss_count_o(dtlb_miss_count_o)
  );

endmodule

`default_nettype wire

// ==== tests/mmu_walk_assert.sv ====
/*
 * Walker protocol assertions
 * one read outstanding, one-cycle result strobe,
 * idle after reset, reads only from a busy walker
 */

`timescale 1ns/1ns
`default_nettype none

module mmu_walk_assert import mmu_pkg::*; (
  input  wire logic   clk_i,
  input  wire logic   rst_i,
  input  wire logic   busy_i,
  input  mem_req_t    mem_req_i,
  input  mem_rsp_t    mem_rsp_i,
  input  walk_result_t walk_result_i
);

  // set by a read strobe, cleared by its response
  logic outstanding_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding_q <= 1'b0;
    end else if (mem_req_i.valid) begin
      outstanding_q <= 1'b1;
    end else if (mem_rsp_i.valid) begin
      outstanding_q <= 1'b0;
    end
  end

  single_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_i.valid |-> !outstanding_q)
    else $error("memory read issued with a read outstanding");

  result_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    walk_result_i.valid |=> !walk_result_i.valid)
    else $error("walk result strobe longer than one cycle");

  idle_after_reset: assert property (@(posedge clk_i)
    rst_i |=> !busy_i)
    else $error("walker busy right after reset");

  no_read_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_i.valid |-> busy_i)
    else $error("memory read issued by an idle walker");

endmodule

bind ptw mmu_walk_assert u_walk_assert (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .busy_i       (walker_busy_o),
  .mem_req_i    (mem_req_o),
  .mem_rsp_i    (mem_rsp_i),
  .walk_result_i(walk_result_o)
);

`default_nettype wire

// ==== tests/tb_mmu_walk.sv ====
/*
 * Sv39 page walk subsystem testbench
 * sparse page table memory with random response delay,
 * directed walks for 4K and 2M leaves, permission and pmp faults,
 * miss priority and flush with a pending read
 */

`timescale 1ns/1ns
`default_nettype none

`include "mmu_settings.svh"

module tb_mmu_walk import mmu_pkg::*; ();

  localparam int WAIT_LIMIT = 60;
  localparam int KIND_ITLB  = 0;
  localparam int KIND_DTLB  = 1;
  localparam int KIND_FAULT = 2;

  // pte flag bits, v at bit 0
  localparam logic [7:0] F_V = 8'h01;
  localparam logic [7:0] F_R = 8'h02;
  localparam logic [7:0] F_W = 8'h04;
  localparam logic [7:0] F_X = 8'h08;
  localparam logic [7:0] F_A = 8'h40;
  localparam logic [7:0] F_D = 8'h80;

  // page table pages
  localparam logic [21:0] ROOT_PPN = 22'h00100;
  localparam logic [21:0] L1_PPN   = 22'h00101;
  localparam logic [21:0] L2_PPN   = 22'h00102;
  localparam logic [21:0] SP_PPN   = 22'h00103;
  localparam logic [7:0]  ASID     = 8'h5a;

  logic                                           clk = 1'b0;
  logic                                           rst;
  logic                                           flush;
  logic                                           itlb_miss;
  logic [`MMU_VA_WIDTH-1:0]                       itlb_vaddr;
  logic                                           dtlb_miss;
  logic [`MMU_VA_WIDTH-1:0]                       dtlb_vaddr;
  logic                                           dtlb_is_store;
  logic [`MMU_ASID_WIDTH-1:0]                     asid;
  logic [`MMU_PPN_WIDTH-1:0]                      satp_ppn;
  logic                                           mxr;
  pmp_cfg_t [`MMU_PMP_ENTRIES-1:0]                pmp_cfg;
  logic [`MMU_PMP_ENTRIES-1:0][`MMU_PA_WIDTH-3:0] pmp_addr;
  mem_rsp_t                                       mem_rsp = '0;
  mem_req_t                                       mem_req;
  tlb_update_t                                    itlb_update;
  tlb_update_t                                    dtlb_update;
  walk_fault_t                                    walk_fault;
  logic [`MMU_CNT_WIDTH-1:0]                      itlb_count;
  logic [`MMU_CNT_WIDTH-1:0]                      dtlb_count;

  // sparse pte memory, absent entries read as zero (invalid pte)
  logic [63:0]              page_mem [logic [`MMU_PA_WIDTH-1:0]];
  logic [`MMU_PA_WIDTH-1:0] rsp_addr;
  int                       rsp_wait = 0;
  logic [31:0]              lcg_state = 32'd46;
  logic [63:0]              leaf_4k;
  logic [63:0]              leaf_2m;
  logic [63:0]              leaf_xonly;
  tlb_update_t              got_upd;
  walk_fault_t              got_fault;

  always #50 clk = ~clk;

  mmu_walk_top dut0 (
    .clk_i            (clk),
    .rst_i            (rst),
    .flush_i          (flush),
    .itlb_miss_i      (itlb_miss),
    .itlb_vaddr_i     (itlb_vaddr),
    .dtlb_miss_i      (dtlb_miss),
    .dtlb_vaddr_i     (dtlb_vaddr),
    .dtlb_is_store_i  (dtlb_is_store),
    .asid_i           (asid),
    .satp_ppn_i       (satp_ppn),
    .mxr_i            (mxr),
    .pmp_cfg_i        (pmp_cfg),
    .pmp_addr_i       (pmp_addr),
    .mem_rsp_i        (mem_rsp),
    .mem_req_o        (mem_req),
    .itlb_update_o    (itlb_update),
    .dtlb_update_o    (dtlb_update),
    .walk_fault_o     (walk_fault),
    .itlb_miss_count_o(itlb_count),
    .dtlb_miss_count_o(dtlb_count)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic logic [63:0] mk_pte(input logic [21:0] ppn, input logic [7:0] flags);
    return {10'd0, 22'd0, ppn, 2'b00, flags};
  endfunction

  // Sv39 pte address, table page plus index times 8
  function automatic logic [33:0] pte_addr(input logic [21:0] ppn, input logic [8:0] idx);
    return {ppn, idx, 3'b000};
  endfunction

  function automatic logic [38:0] make_va(input logic [8:0] i2, input logic [8:0] i1,
                                          input logic [8:0] i0, input logic [11:0] off);
    return {i2, i1, i0, off};
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t ns: %s, got %0h expected %0h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic build_tables();
    leaf_4k    = mk_pte(22'h02345, F_V | F_R | F_W | F_A | F_D);
    leaf_2m    = mk_pte(22'h00200, F_V | F_X | F_A);
    leaf_xonly = mk_pte(22'h00a00, F_V | F_X | F_A);
    page_mem[pte_addr(ROOT_PPN, 9'd1)] = mk_pte(L1_PPN, F_V);
    page_mem[pte_addr(ROOT_PPN, 9'd4)] = mk_pte(SP_PPN, F_V);
    page_mem[pte_addr(L1_PPN, 9'd2)]   = mk_pte(L2_PPN, F_V);
    page_mem[pte_addr(L2_PPN, 9'd3)]   = leaf_4k;
    page_mem[pte_addr(SP_PPN, 9'd5)]   = leaf_2m;
    // low ppn bit set, not a 2M boundary
    page_mem[pte_addr(SP_PPN, 9'd6)]   = mk_pte(22'h00201, F_V | F_X | F_A);
    page_mem[pte_addr(SP_PPN, 9'd7)]   = mk_pte(22'h00400, F_V | F_R | F_A);
    page_mem[pte_addr(SP_PPN, 9'd8)]   = mk_pte(22'h00600, F_V | F_R);
    page_mem[pte_addr(SP_PPN, 9'd9)]   = mk_pte(22'h00800, F_V | F_R | F_W | F_A);
    page_mem[pte_addr(SP_PPN, 9'd10)]  = leaf_xonly;
  endtask

  // ----------------------------------------
  // memory model, 1 to 3 cycles per read
  // ----------------------------------------
  always @(negedge clk) begin
    if (!rst && mem_req.valid) begin
      rsp_addr = mem_req.paddr;
      rsp_wait = 1 + int'(lcg_next() % 32'd3);
    end
  end

  always @(posedge clk) begin
    mem_rsp.valid <= 1'b0;
    if (rsp_wait == 1) begin
      mem_rsp <= '{valid: 1'b1,
                   data: page_mem.exists(rsp_addr) ? page_mem[rsp_addr] : 64'h0};
    end
    if (rsp_wait != 0) begin
      rsp_wait = rsp_wait - 1;
    end
  end

  // ----------------------------------------
  // walk sequencing
  // ----------------------------------------
  // sampled mid-cycle, exactly one strobe port may fire
  task automatic wait_strobe(output int kind);
    int cycles;
    kind   = -1;
    cycles = 0;
    while (kind < 0) begin
      @(negedge clk);
      cycles++;
      if (itlb_update.valid || dtlb_update.valid || walk_fault.valid) begin
        check(64'($countones({itlb_update.valid, dtlb_update.valid, walk_fault.valid})),
              64'd1, "strobes in one cycle");
        got_upd   = itlb_update.valid ? itlb_update : dtlb_update;
        got_fault = walk_fault;
        kind = itlb_update.valid ? KIND_ITLB : (dtlb_update.valid ? KIND_DTLB : KIND_FAULT);
      end else if (cycles > WAIT_LIMIT) begin
        stop_with_failure("timeout: the walker gave no update or fault strobe");
      end
    end
  endtask

  task automatic wait_mem_req();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!mem_req.valid) begin
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_with_failure("timeout: the walker issued no memory read");
      end
      @(negedge clk);
    end
  endtask

  // miss level held until the strobe, dropped on the next edge
  task automatic run_walk(input logic instr, input logic [38:0] va, input logic store,
                          output int kind);
    @(posedge clk);
    if (instr) begin
      itlb_miss  <= 1'b1;
      itlb_vaddr <= va;
    end else begin
      dtlb_miss     <= 1'b1;
      dtlb_vaddr    <= va;
      dtlb_is_store <= store;
    end
    wait_strobe(kind);
    @(posedge clk);
    itlb_miss <= 1'b0;
    dtlb_miss <= 1'b0;
  endtask

  task automatic expect_update(input int kind, input int exp_kind, input logic [38:0] va,
                               input logic [63:0] pte, input page_size_e size);
    check(64'(kind), 64'(exp_kind), "strobe port");
    check(64'(got_upd.vpn), 64'(va[38:12]), "update vpn");
    check(64'(got_upd.asid), 64'(ASID), "update asid");
    check(64'(got_upd.size), 64'(size), "update size");
    check(got_upd.content, pte, "update content");
  endtask

  task automatic expect_fault(input int kind, input fault_kind_e fk, input logic instr,
                              input logic [38:0] va);
    check(64'(kind), 64'(KIND_FAULT), "strobe port");
    check(64'(got_fault.kind), 64'(fk), "fault kind");
    check(64'(got_fault.is_instr), 64'(instr), "fault side");
    check(64'(got_fault.vaddr), 64'(va), "fault vaddr");
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_dtlb_4k();
    int kind;
    run_walk(1'b0, make_va(9'd1, 9'd2, 9'd3, 12'h123), 1'b0, kind);
    expect_update(kind, KIND_DTLB, make_va(9'd1, 9'd2, 9'd3, 12'h123), leaf_4k, SIZE_4K);
    check(64'(dtlb_count), 64'd1, "dtlb miss count");
  endtask

  task automatic test_itlb_2m();
    int kind;
    run_walk(1'b1, make_va(9'd4, 9'd5, 9'd0, 12'h0), 1'b0, kind);
    expect_update(kind, KIND_ITLB, make_va(9'd4, 9'd5, 9'd0, 12'h0), leaf_2m, SIZE_2M);
    run_walk(1'b1, make_va(9'd4, 9'd6, 9'd0, 12'h0), 1'b0, kind);
    expect_fault(kind, FAULT_PAGE, 1'b1, make_va(9'd4, 9'd6, 9'd0, 12'h0));
    check(64'(itlb_count), 64'd2, "itlb miss count");
  endtask

  task automatic test_perm_faults();
    int kind;
    // fetch from a page without x
    run_walk(1'b1, make_va(9'd4, 9'd7, 9'd0, 12'h0), 1'b0, kind);
    expect_fault(kind, FAULT_PAGE, 1'b1, make_va(9'd4, 9'd7, 9'd0, 12'h0));
    // accessed bit clear
    run_walk(1'b0, make_va(9'd4, 9'd8, 9'd0, 12'h0), 1'b0, kind);
    expect_fault(kind, FAULT_PAGE, 1'b0, make_va(9'd4, 9'd8, 9'd0, 12'h0));
    // store to a clean page
    run_walk(1'b0, make_va(9'd4, 9'd9, 9'd0, 12'h0), 1'b1, kind);
    expect_fault(kind, FAULT_PAGE, 1'b0, make_va(9'd4, 9'd9, 9'd0, 12'h0));
    run_walk(1'b0, make_va(9'd4, 9'd10, 9'd0, 12'h0), 1'b0, kind);
    expect_fault(kind, FAULT_PAGE, 1'b0, make_va(9'd4, 9'd10, 9'd0, 12'h0));
    // same x-only page is readable once mxr is set
    @(posedge clk);
    mxr <= 1'b1;
    run_walk(1'b0, make_va(9'd4, 9'd10, 9'd0, 12'h0), 1'b0, kind);
    expect_update(kind, KIND_DTLB, make_va(9'd4, 9'd10, 9'd0, 12'h0), leaf_xonly, SIZE_2M);
    mxr <= 1'b0;
  endtask

  task automatic test_pmp_deny();
    int kind;
    @(posedge clk);
    // below the L1 table readable, the L1 table page itself not
    pmp_cfg[0]  <= '{lock: 1'b0, rsvd: 3'd0, a_tor: 1'b1, x: 1'b0, w: 1'b0, r: 1'b1};
    pmp_addr[0] <= {L1_PPN, 10'd0};
    pmp_cfg[1]  <= '{lock: 1'b0, rsvd: 3'd0, a_tor: 1'b1, x: 1'b0, w: 1'b0, r: 1'b0};
    pmp_addr[1] <= {L2_PPN, 10'd0};
    run_walk(1'b0, make_va(9'd1, 9'd2, 9'd3, 12'h0), 1'b0, kind);
    expect_fault(kind, FAULT_ACCESS, 1'b0, make_va(9'd1, 9'd2, 9'd3, 12'h0));
    check(64'(got_fault.bad_paddr), 64'(pte_addr(L1_PPN, 9'd2)), "fault bad_paddr");
    pmp_cfg <= '0;
  endtask

  task automatic test_priority_flush();
    int kind;
    @(posedge clk);
    dtlb_miss     <= 1'b1;
    dtlb_vaddr    <= make_va(9'd1, 9'd2, 9'd3, 12'h0);
    dtlb_is_store <= 1'b0;
    itlb_miss     <= 1'b1;
    itlb_vaddr    <= make_va(9'd4, 9'd5, 9'd0, 12'h0);
    wait_strobe(kind);
    expect_update(kind, KIND_DTLB, make_va(9'd1, 9'd2, 9'd3, 12'h0), leaf_4k, SIZE_4K);
    @(posedge clk);
    dtlb_miss <= 1'b0;
    wait_strobe(kind);
    expect_update(kind, KIND_ITLB, make_va(9'd4, 9'd5, 9'd0, 12'h0), leaf_2m, SIZE_2M);
    @(posedge clk);
    itlb_miss  <= 1'b0;
    dtlb_miss  <= 1'b1;
    // flush while the root read is in flight, tlb drops its miss too
    wait_mem_req();
    @(posedge clk);
    flush     <= 1'b1;
    dtlb_miss <= 1'b0;
    @(posedge clk);
    flush <= 1'b0;
    // longer than a whole three-level walk at the slowest memory
    repeat (24) begin
      @(negedge clk);
      check(64'({itlb_update.valid, dtlb_update.valid, walk_fault.valid}), 64'd0,
            "strobe after flush");
    end
    run_walk(1'b0, make_va(9'd1, 9'd2, 9'd3, 12'h0), 1'b0, kind);
    expect_update(kind, KIND_DTLB, make_va(9'd1, 9'd2, 9'd3, 12'h0), leaf_4k, SIZE_4K);
  endtask

  initial begin
    rst           = 1'b1;
    flush         = 1'b0;
    itlb_miss     = 1'b0;
    itlb_vaddr    = '0;
    dtlb_miss     = 1'b0;
    dtlb_vaddr    = '0;
    dtlb_is_store = 1'b0;
    asid          = ASID;
    satp_ppn      = ROOT_PPN;
    mxr           = 1'b0;
    pmp_cfg       = '0;
    pmp_addr      = '0;
    build_tables();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    test_dtlb_4k();
    test_itlb_2m();
    test_perm_faults();
    test_pmp_deny();
    test_priority_flush();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+common
common/mmu_pkg.sv
ptw/pmp_check.sv
ptw/ptw.sv
logic/miss_arbiter.sv
logic/walk_result_stage.sv
logic/mmu_walk_top.sv
tests/mmu_walk_assert.sv
tests/tb_mmu_walk.sv

// ==== Makefile ====
# Verilator build for the Sv39 page walk testbench

VERILATOR  ?= verilator
TOP        := tb_mmu_walk
FILELIST   := all.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the testbench ends a failing run with $$fatal, so the exit status carries the result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
